// File: axil_pkg.sv
package axil_pkg;

   localparam int AXIL_ADDR_WIDTH = 8;
   localparam int AXIL_DATA_WIDTH = 32;
   localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

   // Master to slave.
   typedef struct packed {
      logic                       aw_valid;
      logic [AXIL_ADDR_WIDTH-1:0] aw_addr;
      logic                       w_valid;
      logic [AXIL_DATA_WIDTH-1:0] w_data;
      logic [AXIL_STRB_WIDTH-1:0] w_strb;
      logic                       b_ready;
      logic                       ar_valid;
      logic [AXIL_ADDR_WIDTH-1:0] ar_addr;
      logic                       r_ready;
   } axil_req_t;

   // Slave to master.
   typedef struct packed {
      logic                       aw_ready;
      logic                       w_ready;
      logic                       b_valid;
      logic [1:0]                 b_resp;
      logic                       ar_ready;
      logic                       r_valid;
      logic [AXIL_DATA_WIDTH-1:0] r_data;
      logic [1:0]                 r_resp;
   } axil_rsp_t;

   // Register map.
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL    = 8'h00;
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_DOPPLER = 8'h04;
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_STATUS  = 8'h08;
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_ACC_I   = 8'h0C;
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_ACC_Q   = 8'h10;
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_ENERGY  = 8'h14;

   // Response codes.
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: carrier_nco.sv
`timescale 1ns/1ps

module carrier_nco
   import gps_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  logic                             clear_i,
   input  logic                             enable_i,
   input  logic signed [DOPPLER_WIDTH-1:0]  doppler_i,
   output logic signed [CARRIER_WIDTH-1:0]  cos_o,
   output logic signed [CARRIER_WIDTH-1:0]  sin_o
);

   logic [PHASE_WIDTH-1:0]     phase_q;
   logic [PHASE_WIDTH-1:0]     phase_inc;
   logic [LUT_INDEX_WIDTH-1:0] lut_index;

   // IF step plus the sign-extended Doppler offset.
   assign phase_inc = F_IF_INC
                    + {{(PHASE_WIDTH-DOPPLER_WIDTH){doppler_i[DOPPLER_WIDTH-1]}}, doppler_i};

   // Top phase bits select the table entry.
   assign lut_index = phase_q[PHASE_WIDTH-1 -: LUT_INDEX_WIDTH];

   always_ff @(posedge clk) begin
      if (!rst_n_i || clear_i) begin
         phase_q <= '0;
      end else if (enable_i) begin
         phase_q <= phase_q + phase_inc;
      end
   end

   // The table is read from the phase before the update,
   // so the pair seen next cycle belongs to the enabled sample.
   always_ff @(posedge clk) begin
      cos_o <= COS_TABLE[lut_index];
      sin_o <= SIN_TABLE[lut_index];
   end

endmodule

// File: code_track.sv
`timescale 1ns/1ps

module code_track
   import gps_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         clear_i,
   input  logic                         valid_i,
   input  logic                         ca_bit_i,
   input  logic signed [MIX_WIDTH-1:0]  baseband_i,
   output logic signed [ACC_WIDTH-1:0]  acc_o
);

   logic signed [MIX_WIDTH-1:0] wiped_q;
   logic                        wiped_valid_q;

   // Code wipe-off. A zero chip flips the sign.
   always_ff @(posedge clk) begin
      wiped_q <= ca_bit_i ? baseband_i : -baseband_i;
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i || clear_i) begin
         wiped_valid_q <= 1'b0;
      end else begin
         wiped_valid_q <= valid_i;
      end
   end

   // Second cycle adds the wiped value into the sum.
   always_ff @(posedge clk) begin
      if (!rst_n_i || clear_i) begin
         acc_o <= '0;
      end else if (wiped_valid_q) begin
         acc_o <= acc_o + {{(ACC_WIDTH-MIX_WIDTH){wiped_q[MIX_WIDTH-1]}}, wiped_q};
      end
   end

endmodule

// File: compile.f
gps_pkg.sv
axil_pkg.sv
carrier_nco.sv
code_track.sv
subchannel.sv
correlator_regs.sv
correlator_top.sv
tb_clk_gen.sv
tb_correlator.sv

// File: correlator_regs.sv
`timescale 1ns/1ps

module correlator_regs
   import gps_pkg::*;
   import axil_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  axil_req_t                        axil_req_i,
   output axil_rsp_t                        axil_rsp_o,
   input  acc_pair_t                        acc_i,
   input  logic                             acc_done_i,
   output logic signed [DOPPLER_WIDTH-1:0]  doppler_o,
   output logic                             clear_o
);

   logic aw_ready_q;
   logic b_valid_q;
   logic [1:0] b_resp_q;
   logic ar_ready_q;
   logic r_valid_q;
   logic [AXIL_DATA_WIDTH-1:0] r_data_q;
   logic [1:0] r_resp_q;
   logic wr_fire;
   logic rd_fire;
   logic [1:0] wr_resp;
   logic [1:0] rd_resp;
   logic [AXIL_DATA_WIDTH-1:0] rd_data;

   logic done_q;
   logic signed [ACC_WIDTH-1:0] snap_i_q;
   logic signed [ACC_WIDTH-1:0] snap_q_q;
   logic [ACC_WIDTH:0] energy_q;
   logic [ACC_WIDTH-1:0] mag_i;
   logic [ACC_WIDTH-1:0] mag_q;

   // Handshake completes while ready is up and the master still holds valid.
   assign wr_fire = aw_ready_q && axil_req_i.aw_valid && axil_req_i.w_valid;
   assign rd_fire = ar_ready_q && axil_req_i.ar_valid;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         aw_ready_q <= 1'b0;
         b_valid_q  <= 1'b0;
         b_resp_q   <= RESP_OKAY;
         ar_ready_q <= 1'b0;
         r_valid_q  <= 1'b0;
         r_resp_q   <= RESP_OKAY;
      end else begin
         aw_ready_q <= axil_req_i.aw_valid && axil_req_i.w_valid && !aw_ready_q && !b_valid_q;
         if (wr_fire) begin
            b_valid_q <= 1'b1;
            b_resp_q  <= wr_resp;
         end else if (axil_req_i.b_ready) begin
            b_valid_q <= 1'b0;
         end
         ar_ready_q <= axil_req_i.ar_valid && !ar_ready_q && !r_valid_q;
         if (rd_fire) begin
            r_valid_q <= 1'b1;
            r_resp_q  <= rd_resp;
         end else if (axil_req_i.r_ready) begin
            r_valid_q <= 1'b0;
         end
      end
   end

   // Read data is held until the master takes it.
   always_ff @(posedge clk) begin
      if (rd_fire) begin
         r_data_q <= rd_data;
      end
   end

   // Status and results are read-only, so writes there are dropped.
   always_comb begin
      case (axil_req_i.aw_addr)
         REG_CTRL, REG_DOPPLER, REG_STATUS,
         REG_ACC_I, REG_ACC_Q, REG_ENERGY: wr_resp = RESP_OKAY;
         default:                          wr_resp = RESP_SLVERR;
      endcase
   end

   always_comb begin
      rd_data = '0;
      rd_resp = RESP_OKAY;
      case (axil_req_i.ar_addr)
         REG_CTRL:    rd_data = '0;
         REG_DOPPLER: rd_data = {{(AXIL_DATA_WIDTH-DOPPLER_WIDTH){doppler_o[DOPPLER_WIDTH-1]}},
                                 doppler_o};
         REG_STATUS:  rd_data = {{(AXIL_DATA_WIDTH-1){1'b0}}, done_q};
         REG_ACC_I:   rd_data = {{(AXIL_DATA_WIDTH-ACC_WIDTH){snap_i_q[ACC_WIDTH-1]}}, snap_i_q};
         REG_ACC_Q:   rd_data = {{(AXIL_DATA_WIDTH-ACC_WIDTH){snap_q_q[ACC_WIDTH-1]}}, snap_q_q};
         REG_ENERGY:  rd_data = {{(AXIL_DATA_WIDTH-ACC_WIDTH-1){1'b0}}, energy_q};
         default:     rd_resp = RESP_SLVERR;
      endcase
   end

   // Self-clearing bit. The datapath sees it in the handshake cycle.
   assign clear_o = wr_fire && (axil_req_i.aw_addr == REG_CTRL)
                 && axil_req_i.w_strb[0] && axil_req_i.w_data[0];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         doppler_o <= '0;
      end else if (wr_fire && axil_req_i.aw_addr == REG_DOPPLER) begin
         if (axil_req_i.w_strb[0]) begin
            doppler_o[7:0] <= axil_req_i.w_data[7:0];
         end
         if (axil_req_i.w_strb[1]) begin
            doppler_o[15:8] <= axil_req_i.w_data[15:8];
         end
      end
   end

   // Magnitudes as unsigned, so the most negative sum still fits.
   assign mag_i = acc_i.acc_i[ACC_WIDTH-1] ? -acc_i.acc_i : acc_i.acc_i;
   assign mag_q = acc_i.acc_q[ACC_WIDTH-1] ? -acc_i.acc_q : acc_i.acc_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         done_q   <= 1'b0;
         snap_i_q <= '0;
         snap_q_q <= '0;
         energy_q <= '0;
      end else begin
         if (clear_o) begin
            done_q <= 1'b0;
         end
         if (acc_done_i) begin
            done_q   <= 1'b1;
            snap_i_q <= acc_i.acc_i;
            snap_q_q <= acc_i.acc_q;
            energy_q <= mag_i + mag_q;
         end
      end
   end

   always_comb begin
      axil_rsp_o.aw_ready = aw_ready_q;
      axil_rsp_o.w_ready  = aw_ready_q;
      axil_rsp_o.b_valid  = b_valid_q;
      axil_rsp_o.b_resp   = b_resp_q;
      axil_rsp_o.ar_ready = ar_ready_q;
      axil_rsp_o.r_valid  = r_valid_q;
      axil_rsp_o.r_data   = r_data_q;
      axil_rsp_o.r_resp   = r_resp_q;
   end

endmodule

// File: correlator_top.sv
`timescale 1ns/1ps

module correlator_top
   import gps_pkg::*;
   import axil_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  axil_req_t axil_req_i,
   output axil_rsp_t axil_rsp_o,
   input  sample_t   sample_i
);

   logic signed [DOPPLER_WIDTH-1:0] doppler;
   logic                            clear;
   acc_pair_t                       acc;
   logic                            acc_done;

   // Host registers and result snapshot.
   correlator_regs u_regs (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .axil_req_i (axil_req_i),
      .axil_rsp_o (axil_rsp_o),
      .acc_i      (acc),
      .acc_done_i (acc_done),
      .doppler_o  (doppler),
      .clear_o    (clear)
   );

   subchannel u_subchannel (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear),
      .sample_i   (sample_i),
      .doppler_i  (doppler),
      .acc_o      (acc),
      .acc_done_o (acc_done)
   );

endmodule

// File: gps_pkg.sv
package gps_pkg;

   // Signal path widths.
   localparam int SAMPLE_WIDTH    = 3;
   localparam int DOPPLER_WIDTH   = 16;
   localparam int PHASE_WIDTH     = 24;
   localparam int LUT_INDEX_WIDTH = 4;
   localparam int CARRIER_WIDTH   = 3;
   localparam int MIX_WIDTH       = 6;
   localparam int ACC_WIDTH       = 24;

   // Phase step per sample for the front-end intermediate frequency.
   localparam logic [PHASE_WIDTH-1:0] F_IF_INC = 24'h3EF0A3;

   // Samples wait this long for the carrier to line up.
   localparam int DATA_DELAY = 4;

   // Carrier tables over one cycle, amplitude 3.
   localparam logic signed [CARRIER_WIDTH-1:0] COS_TABLE [0:15] = '{
      3'sd3,  3'sd3,  3'sd2,  3'sd1,
      3'sd0, -3'sd1, -3'sd2, -3'sd3,
     -3'sd3, -3'sd3, -3'sd2, -3'sd1,
      3'sd0,  3'sd1,  3'sd2,  3'sd3
   };

   localparam logic signed [CARRIER_WIDTH-1:0] SIN_TABLE [0:15] = '{
      3'sd0,  3'sd1,  3'sd2,  3'sd3,
      3'sd3,  3'sd3,  3'sd2,  3'sd1,
      3'sd0, -3'sd1, -3'sd2, -3'sd3,
     -3'sd3, -3'sd3, -3'sd2, -3'sd1
   };

   // One front-end item.
   typedef struct packed {
      logic                           valid;
      logic                           last;
      logic                           ca_bit;
      logic signed [SAMPLE_WIDTH-1:0] data;
   } sample_t;

   typedef struct packed {
      logic signed [ACC_WIDTH-1:0] acc_i;
      logic signed [ACC_WIDTH-1:0] acc_q;
   } acc_pair_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_correlator \
   -f compile.f -o tb_correlator_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_correlator_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
   exit 1
fi
if ! grep -q "Testbench passed" "$SIM_LOG"; then
   echo "Simulation log has no result line"
   exit 1
fi
exit 0

// File: subchannel.sv
`timescale 1ns/1ps

module subchannel
   import gps_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  logic                             clear_i,
   input  sample_t                          sample_i,
   input  logic signed [DOPPLER_WIDTH-1:0]  doppler_i,
   output acc_pair_t                        acc_o,
   output logic                             acc_done_o
);

   logic [DATA_DELAY-1:0]          valid_pipe;
   logic [DATA_DELAY-1:0]          ca_pipe;
   logic signed [SAMPLE_WIDTH-1:0] data_pipe [DATA_DELAY];
   logic [DATA_DELAY+2:0]          done_pipe;

   logic signed [CARRIER_WIDTH-1:0] carrier_cos;
   logic signed [CARRIER_WIDTH-1:0] carrier_sin;
   logic signed [MIX_WIDTH-1:0]     mix_i;
   logic signed [MIX_WIDTH-1:0]     mix_q;

   logic signed [MIX_WIDTH-1:0] prod_i_q;
   logic signed [MIX_WIDTH-1:0] prod_q_q;
   logic                        prod_ca_q;
   logic                        prod_valid_q;

   // Valid goes through the same delay as the data.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_pipe <= '0;
         done_pipe  <= '0;
      end else begin
         valid_pipe <= {valid_pipe[DATA_DELAY-2:0], sample_i.valid};
         done_pipe  <= {done_pipe[DATA_DELAY+1:0], sample_i.valid && sample_i.last};
      end
   end

   always_ff @(posedge clk) begin
      ca_pipe      <= {ca_pipe[DATA_DELAY-2:0], sample_i.ca_bit};
      data_pipe[0] <= sample_i.data;
      for (int s = 1; s < DATA_DELAY; s++) begin
         data_pipe[s] <= data_pipe[s-1];
      end
   end

   // NCO steps one stage ahead so its output meets the delayed sample.
   carrier_nco u_carrier_nco (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .clear_i   (clear_i),
      .enable_i  (valid_pipe[DATA_DELAY-2]),
      .doppler_i (doppler_i),
      .cos_o     (carrier_cos),
      .sin_o     (carrier_sin)
   );

   // Carrier wipe-off.
   assign mix_i = data_pipe[DATA_DELAY-1] * carrier_cos;
   assign mix_q = data_pipe[DATA_DELAY-1] * carrier_sin;

   // Register the products before the track arms.
   always_ff @(posedge clk) begin
      prod_i_q  <= mix_i;
      prod_q_q  <= mix_q;
      prod_ca_q <= ca_pipe[DATA_DELAY-1];
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i || clear_i) begin
         prod_valid_q <= 1'b0;
      end else begin
         prod_valid_q <= valid_pipe[DATA_DELAY-1];
      end
   end

   code_track track_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear_i),
      .valid_i    (prod_valid_q),
      .ca_bit_i   (prod_ca_q),
      .baseband_i (prod_i_q),
      .acc_o      (acc_o.acc_i)
   );

   code_track track_q (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear_i),
      .valid_i    (prod_valid_q),
      .ca_bit_i   (prod_ca_q),
      .baseband_i (prod_q_q),
      .acc_o      (acc_o.acc_q)
   );

   // Feed complete lands as the last sum settles.
   assign acc_done_o = done_pipe[DATA_DELAY+2];

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int RESET_CYCLES = 8;

   // 20 ns period.
   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   // Reset is released on a rising edge after the hold time.
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// File: tb_correlator.sv
`timescale 1ns/1ps

module tb_correlator
   import gps_pkg::*;
   import axil_pkg::*;
();

   localparam int WAIT_LIMIT     = 100;
   localparam int POLL_LIMIT     = 40;
   localparam int RESULT_LATENCY = DATA_DELAY + 4;
   localparam int NUM_CASES      = 6;
   localparam logic [7:0] UNMAPPED_ADDR = 8'h20;
   localparam logic [7:0] RESET_REGS [5] = '{REG_DOPPLER, REG_STATUS, REG_ACC_I,
                                            REG_ACC_Q, REG_ENERGY};

   typedef struct {
      string name;
      int    doppler;
      int    length;
      bit    gaps;
      bit    clear_first;
   } case_t;

   logic      clk;
   logic      rst_n;
   axil_req_t axil_req;
   axil_rsp_t axil_rsp;
   sample_t   sample;

   integer seed = 62;
   int     mismatch_count = 0;
   int     timeout_count = 0;
   case_t  cases [NUM_CASES];

   // Reference model state.
   logic [PHASE_WIDTH-1:0] model_phase;
   int                     model_doppler;
   int                     model_i;
   int                     model_q;

   tb_clk_gen u_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   correlator_top DUT (
      .clk        (clk),
      .rst_n_i    (rst_n),
      .axil_req_i (axil_req),
      .axil_rsp_o (axil_rsp),
      .sample_i   (sample)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         mismatch_count++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
      timeout_count++;
   endtask

   function automatic int magnitude(input int value);
      return (value < 0) ? -value : value;
   endfunction

   task automatic reset_model();
      model_phase = '0;
      model_i     = 0;
      model_q     = 0;
   endtask

   // One sample takes the carrier of the current phase, then the phase steps.
   task automatic model_sample(input logic signed [SAMPLE_WIDTH-1:0] data, input logic ca_bit);
      logic [LUT_INDEX_WIDTH-1:0] index;
      int value;
      int prod_i;
      int prod_q;
      index  = model_phase[PHASE_WIDTH-1 -: LUT_INDEX_WIDTH];
      value  = data;
      prod_i = value * int'(COS_TABLE[index]);
      prod_q = value * int'(SIN_TABLE[index]);
      if (!ca_bit) begin
         prod_i = -prod_i;
         prod_q = -prod_q;
      end
      model_i += prod_i;
      model_q += prod_q;
      model_phase = model_phase + F_IF_INC + PHASE_WIDTH'(model_doppler);
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      int cycles;
      @(posedge clk);
      axil_req.aw_valid <= 1'b1;
      axil_req.aw_addr  <= addr;
      axil_req.w_valid  <= 1'b1;
      axil_req.w_data   <= data;
      axil_req.w_strb   <= '1;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!axil_rsp.aw_ready && cycles < WAIT_LIMIT);
      if (!axil_rsp.aw_ready) begin
         report_timeout("aw_ready");
      end else begin
         check_value("w_ready", 32'd1, 32'(axil_rsp.w_ready));
      end
      @(posedge clk);
      axil_req.aw_valid <= 1'b0;
      axil_req.w_valid  <= 1'b0;
      axil_req.b_ready  <= 1'b1;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!axil_rsp.b_valid && cycles < WAIT_LIMIT);
      if (!axil_rsp.b_valid) report_timeout("b_valid");
      resp = axil_rsp.b_resp;
      @(posedge clk);
      axil_req.b_ready <= 1'b0;
   endtask

   // Hold delays r_ready by that many cycles while r_data is watched.
   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, input int hold);
      int cycles;
      @(posedge clk);
      axil_req.ar_valid <= 1'b1;
      axil_req.ar_addr  <= addr;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!axil_rsp.ar_ready && cycles < WAIT_LIMIT);
      if (!axil_rsp.ar_ready) report_timeout("ar_ready");
      @(posedge clk);
      axil_req.ar_valid <= 1'b0;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!axil_rsp.r_valid && cycles < WAIT_LIMIT);
      if (!axil_rsp.r_valid) report_timeout("r_valid");
      data = axil_rsp.r_data;
      resp = axil_rsp.r_resp;
      for (int h = 0; h < hold; h++) begin
         @(negedge clk);
         check_value("held r_data", data, axil_rsp.r_data);
         check_value("held r_valid", 32'd1, 32'(axil_rsp.r_valid));
      end
      @(posedge clk);
      axil_req.r_ready <= 1'b1;
      @(posedge clk);
      axil_req.r_ready <= 1'b0;
   endtask

   // The datapath needs quiet cycles after a clear.
   task automatic clear_channel();
      logic [1:0] resp;
      axil_write(REG_CTRL, 32'h1, resp);
      check_value("clear resp", 32'(RESP_OKAY), 32'(resp));
      repeat (RESULT_LATENCY) @(posedge clk);
   endtask

   task automatic send_feed(input int length, input bit gaps);
      sample_t s;
      integer  rnd;
      for (int n = 0; n < length; n++) begin
         rnd = $random(seed);
         if (gaps && rnd[5:4] == 2'b00) begin
            @(posedge clk);
            sample <= '0;
         end
         s.valid  = 1'b1;
         s.last   = (n == length - 1);
         s.ca_bit = rnd[3];
         s.data   = rnd[2:0];
         @(posedge clk);
         sample <= s;
         model_sample(s.data, s.ca_bit);
      end
      @(posedge clk);
      sample <= '0;
   endtask

   task automatic wait_done(input string name);
      logic [31:0] data;
      logic [1:0]  resp;
      int          polls;
      data  = '0;
      polls = 0;
      while (!data[0] && polls < POLL_LIMIT) begin
         axil_read(REG_STATUS, data, resp, 0);
         polls++;
      end
      if (!data[0]) begin
         $display("Timeout: %s never reported done", name);
         timeout_count++;
      end
   endtask

   task automatic check_results(input string name);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(REG_ACC_I, data, resp, 0);
      check_value({name, " acc_i"}, model_i, data);
      check_value({name, " acc_i resp"}, 32'(RESP_OKAY), 32'(resp));
      axil_read(REG_ACC_Q, data, resp, 0);
      check_value({name, " acc_q"}, model_q, data);
      axil_read(REG_ENERGY, data, resp, 0);
      check_value({name, " energy"}, magnitude(model_i) + magnitude(model_q), data);
   endtask

   task automatic run_case(input case_t c);
      logic [1:0] resp;
      if (c.clear_first) begin
         clear_channel();
         reset_model();
      end
      axil_write(REG_DOPPLER, 32'(c.doppler), resp);
      model_doppler = int'($signed(c.doppler[15:0]));
      send_feed(c.length, c.gaps);
      repeat (RESULT_LATENCY) @(posedge clk);
      wait_done(c.name);
      check_results(c.name);
   endtask

   initial begin
      logic [31:0] data;
      logic [1:0]  resp;
      int          cycles;
      axil_req <= '0;
      sample   <= '0;
      reset_model();
      model_doppler = 0;
      cases[0] = '{"zero_doppler", 0, 40, 1'b0, 1'b1};
      cases[1] = '{"pos_doppler", 12000, 60, 1'b0, 1'b1};
      cases[2] = '{"neg_doppler", -9000, 50, 1'b1, 1'b1};
      cases[3] = '{"gapped_feed", 3000, 35, 1'b1, 1'b1};
      cases[4] = '{"accumulate", -6000, 45, 1'b0, 1'b0};
      cases[5] = '{"after_clear", -2500, 30, 1'b1, 1'b0};

      cycles = 0;
      while (!rst_n && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (!rst_n) report_timeout("reset release");

      // Everything reads as zero after reset.
      for (int r = 0; r < 5; r++) begin
         axil_read(RESET_REGS[r], data, resp, 0);
         check_value($sformatf("reset reg 0x%02h", RESET_REGS[r]), 32'd0, data);
         check_value("reset resp", 32'(RESP_OKAY), 32'(resp));
      end

      axil_write(REG_DOPPLER, 32'h1234_8A5C, resp);
      axil_read(REG_DOPPLER, data, resp, 0);
      check_value("doppler negative", 32'hFFFF_8A5C, data);
      axil_write(REG_DOPPLER, 32'hABCD_7001, resp);
      axil_read(REG_DOPPLER, data, resp, 0);
      check_value("doppler positive", 32'h0000_7001, data);

      // The last table entry runs after the clear check below.
      for (int c = 0; c < NUM_CASES - 1; c++) begin
         run_case(cases[c]);
      end

      // Clear drops done and leaves the snapshot alone.
      axil_write(REG_CTRL, 32'h1, resp);
      axil_read(REG_STATUS, data, resp, 0);
      check_value("clear done", 32'd0, data);
      check_results("held snapshot");
      repeat (RESULT_LATENCY) @(posedge clk);
      reset_model();
      run_case(cases[NUM_CASES-1]);

      axil_write(UNMAPPED_ADDR, 32'hFFFF_FFFF, resp);
      check_value("unmapped write resp", 32'(RESP_SLVERR), 32'(resp));
      axil_read(UNMAPPED_ADDR, data, resp, 5);
      check_value("unmapped read resp", 32'(RESP_SLVERR), 32'(resp));
      check_value("unmapped read data", 32'd0, data);
      axil_read(REG_DOPPLER, data, resp, 0);
      check_value("doppler after unmapped write", 32'(model_doppler), data);
      axil_read(REG_STATUS, data, resp, 0);
      check_value("done after unmapped write", 32'd1, data);
      axil_read(REG_ACC_I, data, resp, 6);
      check_value("delayed acc_i", model_i, data);
      check_results("after unmapped access");

      $display("Error counts: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
